// File: logic/wipe_pkg.sv
// Shared constants and types for the secure-wipe register file
// Word width is fixed at 64 bits, two entropy beats of 32 bits make one seed
// Permutations are built by an odd-multiplier mapping, so they are always bijective
package wipe_pkg;

  // Datapath widths
  localparam int unsigned PRNG_W     = 64;
  localparam int unsigned ENT_W      = 32;
  localparam int unsigned PERM_IDX_W = 6;

  // Register file geometry
  localparam int unsigned NUM_BANKS = 4;
  localparam int unsigned NUM_WORDS = 4;
  localparam int unsigned BANK_W    = $clog2(NUM_BANKS);
  localparam int unsigned WORD_W    = $clog2(NUM_WORDS);

  // APB geometry and register offsets
  localparam int unsigned APB_AW = 8;
  localparam int unsigned APB_DW = 32;
  localparam logic [APB_AW-1:0] REG_CMD     = 8'h00;
  localparam logic [APB_AW-1:0] REG_STATUS  = 8'h04;
  localparam logic [APB_AW-1:0] REG_ADDR    = 8'h08;
  localparam logic [APB_AW-1:0] REG_DATA_LO = 8'h0C;
  localparam logic [APB_AW-1:0] REG_DATA_HI = 8'h10;

  // Reset seed and Galois feedback mask for x^64 + x^4 + x^3 + x + 1
  localparam logic [PRNG_W-1:0] LFSR_SEED = 64'h5d2a_3764_37e9_2f4b;
  localparam logic [PRNG_W-1:0] LFSR_TAPS = 64'hD800_0000_0000_0000;

  // PRINCE S-box, nibble n holds S(n)
  localparam logic [63:0] PRINCE_SBOX = 64'h4D5E_0876_19CA_23FB;

  // Entry i of the result is (i * mul + add) mod 64, a bijection for odd mul
  function automatic logic [PRNG_W*PERM_IDX_W-1:0] gen_perm(int unsigned mul,
                                                            int unsigned add);
    logic [PRNG_W*PERM_IDX_W-1:0] perm;
    perm = '0;
    for (int unsigned i = 0; i < PRNG_W; i++) begin
      perm[PERM_IDX_W*i +: PERM_IDX_W] = PERM_IDX_W'((i * mul + add) % PRNG_W);
    end
    return perm;
  endfunction

  localparam logic [PRNG_W*PERM_IDX_W-1:0] LFSR_PERM  = gen_perm(37, 11);
  localparam logic [PRNG_W*PERM_IDX_W-1:0] SHARE_PERM = gen_perm(45, 29);

  typedef enum logic [1:0] {
    CMD_NONE      = 2'd0,
    CMD_WIPE_BANK = 2'd1,
    CMD_WIPE_ALL  = 2'd2,
    CMD_RESEED    = 2'd3
  } wipe_cmd_e;

  typedef enum logic [1:0] {
    ST_IDLE   = 2'd0,
    ST_RESEED = 2'd1,
    ST_WIPE   = 2'd2,
    ST_DONE   = 2'd3
  } wipe_state_e;

  // Two-share word, the plain value is share0 ^ share1
  typedef struct packed {
    logic [PRNG_W-1:0] share0;
    logic [PRNG_W-1:0] share1;
  } wipe_word_t;

  typedef struct packed {
    logic              host_we;
    logic              wipe_we;
    logic [WORD_W-1:0] word;
    wipe_word_t        data;
  } bank_wr_t;

  typedef struct packed {
    logic [PRNG_W-1:0] data;
    logic [BANK_W-1:0] bank;
    logic [WORD_W-1:0] word;
  } host_wdata_t;

endpackage

// File: logic/wipe_prng.sv
// Clearing PRNG, Galois LFSR with permute / PRINCE S-box / permute output
// Not a cryptographic generator, only meant for overwriting register shares
// Reseed needs exactly two entropy beats, the first is the upper seed half
// Reseed has priority, data_ack_o is held low while reseed_req_i is high
`timescale 1ns/100ps

module wipe_prng import wipe_pkg::*; (
  input  logic             clk_i,
  input  logic             rst_ni,

  // PRNG consumer side
  input  logic             data_req_i,
  output logic             data_ack_o,
  output wipe_word_t       data_o,
  input  logic             reseed_req_i,
  output logic             reseed_ack_o,

  // Entropy source side
  output logic             entropy_req_o,
  input  logic             entropy_ack_i,
  input  logic [ENT_W-1:0] entropy_i
);

  logic [PRNG_W-1:0] lfsr_q, lfsr_d;
  logic [PRNG_W-1:0] seed;
  logic              seed_valid;
  logic              lfsr_en;
  logic              beat;
  logic [ENT_W-1:0]  buffer_q;
  logic              buffer_valid_q;
  logic              seed_done_q;
  logic [PRNG_W-1:0] perm_out;
  logic [PRNG_W-1:0] sbox_out;

  // Reseed wins over data requests
  assign data_ack_o = reseed_req_i ? 1'b0 : data_req_i;
  assign lfsr_en    = data_req_i & data_ack_o;

  // Request is masked in the cycle right after the seed loads
  assign entropy_req_o = reseed_req_i & ~seed_done_q;
  assign beat          = entropy_req_o & entropy_ack_i;

  // Second accepted beat completes the seed
  assign seed_valid   = buffer_valid_q & beat;
  assign seed         = {buffer_q, entropy_i};
  assign reseed_ack_o = seed_valid;

  // Valid flag toggles on every beat, so it marks the first half held
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      buffer_valid_q <= 1'b0;
      seed_done_q    <= 1'b0;
    end else begin
      if (beat) begin
        buffer_valid_q <= ~buffer_valid_q;
      end
      seed_done_q <= seed_valid;
    end
  end

  // Upper half of the seed
  always_ff @(posedge clk_i) begin
    if (beat && !buffer_valid_q) begin
      buffer_q <= entropy_i;
    end
  end

  // Seed load has priority over stepping
  always_comb begin
    lfsr_d = lfsr_q;
    if (seed_valid) begin
      lfsr_d = seed;
    end else if (lfsr_en) begin
      lfsr_d = {1'b0, lfsr_q[PRNG_W-1:1]} ^ ({PRNG_W{lfsr_q[0]}} & LFSR_TAPS);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lfsr_q <= LFSR_SEED;
    end else begin
      lfsr_q <= lfsr_d;
    end
  end

  // Nonlinear output path
  always_comb begin
    for (int i = 0; i < PRNG_W; i++) begin
      perm_out[i] = lfsr_q[LFSR_PERM[PERM_IDX_W*i +: PERM_IDX_W]];
    end
    // One S-box per nibble
    for (int n = 0; n < PRNG_W/4; n++) begin
      sbox_out[4*n +: 4] = PRINCE_SBOX[4*perm_out[4*n +: 4] +: 4];
    end
    // Same permutation again after the S-box layer
    for (int i = 0; i < PRNG_W; i++) begin
      data_o.share0[i] = sbox_out[LFSR_PERM[PERM_IDX_W*i +: PERM_IDX_W]];
    end
    // Second share is a separate bit shuffle of the first
    for (int i = 0; i < PRNG_W; i++) begin
      data_o.share1[i] = data_o.share0[SHARE_PERM[PERM_IDX_W*i +: PERM_IDX_W]];
    end
  end

endmodule

// File: logic/wipe_ctrl.sv
// Command FSM for reseed and wipe, plus routing of host writes into the banks
// Commands are only taken in idle, the APB side flags the rest with PSLVERR
// Host writes are not blocked during a wipe, one hitting the bank under wipe is dropped
`timescale 1ns/100ps

module wipe_ctrl import wipe_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_ni,

  // Commands and host writes from the register block
  input  logic                 cmd_valid_i,
  input  wipe_cmd_e            cmd_i,
  input  logic [BANK_W-1:0]    cmd_bank_i,
  input  logic                 host_wvalid_i,
  input  host_wdata_t          host_wdata_i,

  // Status
  output logic                 busy_o,
  output logic                 seeded_o,
  output logic [NUM_BANKS-1:0] wiped_o,

  // PRNG handshakes
  output logic                 data_req_o,
  input  logic                 data_ack_i,
  input  wipe_word_t           prng_data_i,
  output logic                 reseed_req_o,
  input  logic                 reseed_ack_i,

  // One write port per bank
  output bank_wr_t             bank_wr_o [NUM_BANKS]
);

  wipe_state_e          state_q, state_d;
  logic [BANK_W-1:0]    bank_q, bank_d;
  logic [WORD_W-1:0]    word_q, word_d;
  logic                 all_q, all_d;
  logic                 seeded_q, seeded_d;
  logic [NUM_BANKS-1:0] wiped_q, wiped_d;
  logic                 wipe_fire;

  always_comb begin
    state_d      = state_q;
    bank_d       = bank_q;
    word_d       = word_q;
    all_d        = all_q;
    seeded_d     = seeded_q;
    wiped_d      = wiped_q;
    data_req_o   = 1'b0;
    reseed_req_o = 1'b0;
    wipe_fire    = 1'b0;

    unique case (state_q)
      ST_IDLE: begin
        if (cmd_valid_i) begin
          unique case (cmd_i)
            CMD_RESEED: state_d = ST_RESEED;
            CMD_WIPE_BANK: begin
              bank_d  = cmd_bank_i;
              word_d  = '0;
              all_d   = 1'b0;
              state_d = ST_WIPE;
            end
            CMD_WIPE_ALL: begin
              bank_d  = '0;
              word_d  = '0;
              all_d   = 1'b1;
              state_d = ST_WIPE;
            end
            default: ;
          endcase
        end
      end
      ST_RESEED: begin
        reseed_req_o = 1'b1;
        if (reseed_ack_i) begin
          seeded_d = 1'b1;
          state_d  = ST_DONE;
        end
      end
      ST_WIPE: begin
        // One word per accepted PRNG beat
        data_req_o = 1'b1;
        if (data_ack_i) begin
          wipe_fire = 1'b1;
          word_d    = word_q + WORD_W'(1);
          if (word_q == WORD_W'(NUM_WORDS - 1)) begin
            wiped_d[bank_q] = 1'b1;
            if (all_q && bank_q != BANK_W'(NUM_BANKS - 1)) begin
              bank_d = bank_q + BANK_W'(1);
            end else begin
              state_d = ST_DONE;
            end
          end
        end
      end
      ST_DONE: state_d = ST_IDLE;
      default: state_d = ST_IDLE;
    endcase

    // Bank write routing, the wipe owns its bank for the cycle
    for (int b = 0; b < NUM_BANKS; b++) begin
      bank_wr_o[b] = '0;
      if (wipe_fire && bank_q == BANK_W'(b)) begin
        bank_wr_o[b].wipe_we = 1'b1;
        bank_wr_o[b].word    = word_q;
        bank_wr_o[b].data    = prng_data_i;
      end else if (host_wvalid_i && host_wdata_i.bank == BANK_W'(b)) begin
        bank_wr_o[b].host_we     = 1'b1;
        bank_wr_o[b].word        = host_wdata_i.word;
        bank_wr_o[b].data.share0 = host_wdata_i.data;
        // Fresh plain data means the bank is no longer wiped
        wiped_d[b] = 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= ST_IDLE;
      bank_q   <= '0;
      word_q   <= '0;
      all_q    <= 1'b0;
      seeded_q <= 1'b0;
      wiped_q  <= '0;
    end else begin
      state_q  <= state_d;
      bank_q   <= bank_d;
      word_q   <= word_d;
      all_q    <= all_d;
      seeded_q <= seeded_d;
      wiped_q  <= wiped_d;
    end
  end

  assign busy_o   = (state_q != ST_IDLE);
  assign seeded_o = seeded_q;
  assign wiped_o  = wiped_q;

endmodule

// File: logic/wipe_bank.sv
// One bank of two-share words held in flops
// Reset clears both shares of every word
// Host and wipe strobes are never set together, the controller ensures it
`timescale 1ns/100ps

module wipe_bank import wipe_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  bank_wr_t   wr_i,
  output wipe_word_t words_o [NUM_WORDS]
);

  wipe_word_t words_q [NUM_WORDS];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int w = 0; w < NUM_WORDS; w++) begin
        words_q[w] <= '0;
      end
    end else if (wr_i.host_we) begin
      // Unmasked host data, second share zero
      words_q[wr_i.word].share0 <= wr_i.data.share0;
      words_q[wr_i.word].share1 <= '0;
    end else if (wr_i.wipe_we) begin
      // Both shares overwritten from the PRNG
      words_q[wr_i.word] <= wr_i.data;
    end
  end

  assign words_o = words_q;

endmodule

// File: logic/wipe_apb_regs.sv
// Zero-wait APB slave, PREADY is tied high
// DATA_HI write commits the word at ADDR together with the staged DATA_LO
// DATA reads return share0 ^ share1 of the word at ADDR
`timescale 1ns/100ps

module wipe_apb_regs import wipe_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_ni,

  // APB
  input  logic [APB_AW-1:0]    paddr_i,
  input  logic                 psel_i,
  input  logic                 penable_i,
  input  logic                 pwrite_i,
  input  logic [APB_DW-1:0]    pwdata_i,
  output logic [APB_DW-1:0]    prdata_o,
  output logic                 pready_o,
  output logic                 pslverr_o,

  // To the controller
  output logic                 cmd_valid_o,
  output wipe_cmd_e            cmd_o,
  output logic [BANK_W-1:0]    cmd_bank_o,
  output logic                 host_wvalid_o,
  output host_wdata_t          host_wdata_o,

  // Status and bank contents
  input  logic                 busy_i,
  input  logic                 seeded_i,
  input  logic [NUM_BANKS-1:0] wiped_i,
  input  wipe_word_t           bank_words_i [NUM_BANKS][NUM_WORDS]
);

  logic                     wr_acc;
  logic                     cmd_wr;
  logic [BANK_W+WORD_W-1:0] addr_q;
  logic [APB_DW-1:0]        data_lo_q;
  wipe_word_t               rd_word;
  logic [PRNG_W-1:0]        rd_plain;

  // Write access phase
  assign wr_acc = psel_i & penable_i & pwrite_i;
  assign cmd_wr = wr_acc & (paddr_i == REG_CMD);

  // Commands while busy are refused
  assign cmd_valid_o = cmd_wr & ~busy_i;
  assign pslverr_o   = cmd_wr & busy_i;
  assign pready_o    = 1'b1;
  assign cmd_o       = wipe_cmd_e'(pwdata_i[1:0]);
  assign cmd_bank_o  = pwdata_i[5:4];

  // Host word commit
  assign host_wvalid_o     = wr_acc & (paddr_i == REG_DATA_HI);
  assign host_wdata_o.data = {pwdata_i, data_lo_q};
  assign host_wdata_o.bank = addr_q[BANK_W+WORD_W-1:WORD_W];
  assign host_wdata_o.word = addr_q[WORD_W-1:0];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      addr_q <= '0;
    end else if (wr_acc && paddr_i == REG_ADDR) begin
      addr_q <= pwdata_i[BANK_W+WORD_W-1:0];
    end
  end

  // Low half is only staged
  always_ff @(posedge clk_i) begin
    if (wr_acc && paddr_i == REG_DATA_LO) begin
      data_lo_q <= pwdata_i;
    end
  end

  // Unmasked readback of the addressed word
  assign rd_word  = bank_words_i[addr_q[BANK_W+WORD_W-1:WORD_W]][addr_q[WORD_W-1:0]];
  assign rd_plain = rd_word.share0 ^ rd_word.share1;

  always_comb begin
    prdata_o = '0;
    unique case (paddr_i)
      REG_STATUS: begin
        prdata_o[0]    = busy_i;
        prdata_o[1]    = seeded_i;
        prdata_o[11:8] = wiped_i;
      end
      REG_ADDR:    prdata_o[BANK_W+WORD_W-1:0] = addr_q;
      REG_DATA_LO: prdata_o = rd_plain[APB_DW-1:0];
      REG_DATA_HI: prdata_o = rd_plain[PRNG_W-1:APB_DW];
      default: ;
    endcase
  end

endmodule

// File: logic/wipe_top.sv
// Secure-wipe register file top, APB host side and req/ack entropy port
// Four banks of four two-share 64-bit words
`timescale 1ns/100ps

module wipe_top import wipe_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_ni,

  // APB
  input  logic [APB_AW-1:0] paddr_i,
  input  logic              psel_i,
  input  logic              penable_i,
  input  logic              pwrite_i,
  input  logic [APB_DW-1:0] pwdata_i,
  output logic [APB_DW-1:0] prdata_o,
  output logic              pready_o,
  output logic              pslverr_o,

  // Entropy
  output logic              entropy_req_o,
  input  logic              entropy_ack_i,
  input  logic [ENT_W-1:0]  entropy_i
);

  logic                 cmd_valid;
  wipe_cmd_e            cmd;
  logic [BANK_W-1:0]    cmd_bank;
  logic                 host_wvalid;
  host_wdata_t          host_wdata;
  logic                 busy;
  logic                 seeded;
  logic [NUM_BANKS-1:0] wiped;
  logic                 data_req;
  logic                 data_ack;
  wipe_word_t           prng_data;
  logic                 reseed_req;
  logic                 reseed_ack;
  bank_wr_t             bank_wr [NUM_BANKS];
  wipe_word_t           bank_words [NUM_BANKS][NUM_WORDS];

  wipe_apb_regs u_wipe_apb_regs (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .paddr_i       (paddr_i),
    .psel_i        (psel_i),
    .penable_i     (penable_i),
    .pwrite_i      (pwrite_i),
    .pwdata_i      (pwdata_i),
    .prdata_o      (prdata_o),
    .pready_o      (pready_o),
    .pslverr_o     (pslverr_o),
    .cmd_valid_o   (cmd_valid),
    .cmd_o         (cmd),
    .cmd_bank_o    (cmd_bank),
    .host_wvalid_o (host_wvalid),
    .host_wdata_o  (host_wdata),
    .busy_i        (busy),
    .seeded_i      (seeded),
    .wiped_i       (wiped),
    .bank_words_i  (bank_words)
  );

  wipe_ctrl u_wipe_ctrl (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .cmd_valid_i   (cmd_valid),
    .cmd_i         (cmd),
    .cmd_bank_i    (cmd_bank),
    .host_wvalid_i (host_wvalid),
    .host_wdata_i  (host_wdata),
    .busy_o        (busy),
    .seeded_o      (seeded),
    .wiped_o       (wiped),
    .data_req_o    (data_req),
    .data_ack_i    (data_ack),
    .prng_data_i   (prng_data),
    .reseed_req_o  (reseed_req),
    .reseed_ack_i  (reseed_ack),
    .bank_wr_o     (bank_wr)
  );

  wipe_prng u_wipe_prng (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .data_req_i    (data_req),
    .data_ack_o    (data_ack),
    .data_o        (prng_data),
    .reseed_req_i  (reseed_req),
    .reseed_ack_o  (reseed_ack),
    .entropy_req_o (entropy_req_o),
    .entropy_ack_i (entropy_ack_i),
    .entropy_i     (entropy_i)
  );

  // One storage bank per write port
  for (genvar b = 0; b < NUM_BANKS; b++) begin : gen_bank
    wipe_bank u_wipe_bank (
      .clk_i   (clk_i),
      .rst_ni  (rst_ni),
      .wr_i    (bank_wr[b]),
      .words_o (bank_words[b])
    );
  end

endmodule

// File: bench/wipe_sva.sv
// Handshake and readback rules of the secure-wipe block, bound into wipe_top
// All rules except the permutation check are off during reset
`timescale 1ns/100ps

module wipe_sva import wipe_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       entropy_req_i,
  input  logic       reseed_req_i,
  input  logic       reseed_ack_i,
  input  bank_wr_t   bank_wr_i [NUM_BANKS],
  input  wipe_word_t bank_words_i [NUM_BANKS][NUM_WORDS]
);

  // Every output bit must be hit exactly once
  function automatic bit perm_is_bijective(logic [PRNG_W*PERM_IDX_W-1:0] perm);
    logic [PRNG_W-1:0] hit;
    hit = '0;
    for (int i = 0; i < PRNG_W; i++) begin
      hit[perm[PERM_IDX_W*i +: PERM_IDX_W]] = 1'b1;
    end
    return &hit;
  endfunction

  localparam bit PERMS_OK = perm_is_bijective(LFSR_PERM) && perm_is_bijective(SHARE_PERM);

  perm_ok_a: assert property (@(posedge clk_i) PERMS_OK)
    else $error("LFSR_PERM or SHARE_PERM is not a bijection");

  // Entropy is only requested during a reseed
  req_in_reseed_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    entropy_req_i |-> reseed_req_i)
    else $error("entropy request without a reseed in progress");

  // Request drops right after the seed completes
  req_drop_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    reseed_ack_i |=> !entropy_req_i)
    else $error("entropy request still high after the seed");

  for (genvar b = 0; b < NUM_BANKS; b++) begin : gen_bank_chk
    // Host data lands unmasked, share1 reads zero afterwards
    share1_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
      bank_wr_i[b].host_we |=> bank_words_i[b][$past(bank_wr_i[b].word)].share1 == '0)
      else $error("share1 not cleared by a host write");
  end

endmodule

// File: bench/wipe_tb.sv
// Testbench for wipe_top, zero-wait APB host and a random-delay entropy source
// Inputs change 1 ns after the rising edge, outputs are sampled at the falling edge
// Every status poll is bounded, a timeout counts as an error
`timescale 1ns/100ps

module wipe_tb import wipe_pkg::*; ();

  logic              clk_i;
  logic              rst_ni;
  logic [APB_AW-1:0] paddr;
  logic              psel;
  logic              penable;
  logic              pwrite;
  logic [APB_DW-1:0] pwdata;
  logic [APB_DW-1:0] prdata;
  logic              pready;
  logic              pslverr;
  logic              entropy_req;
  logic              entropy_ack;
  logic [ENT_W-1:0]  entropy;

  integer      seed = 32'h92a;
  int          err_cnt = 0;
  int          chk_cnt = 0;
  int          beat_cnt = 0;
  bit          req_seen = 0;
  logic        last_slverr;
  logic [31:0] status_word;
  logic [63:0] first_wipe [NUM_BANKS][NUM_WORDS];

  wipe_top u_wipe_top (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .paddr_i       (paddr),
    .psel_i        (psel),
    .penable_i     (penable),
    .pwrite_i      (pwrite),
    .pwdata_i      (pwdata),
    .prdata_o      (prdata),
    .pready_o      (pready),
    .pslverr_o     (pslverr),
    .entropy_req_o (entropy_req),
    .entropy_ack_i (entropy_ack),
    .entropy_i     (entropy)
  );

  bind wipe_top wipe_sva u_wipe_sva (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .entropy_req_i (entropy_req_o),
    .reseed_req_i  (reseed_req),
    .reseed_ack_i  (reseed_ack),
    .bank_wr_i     (bank_wr),
    .bank_words_i  (bank_words)
  );

  initial clk_i = 1'b0;
  always #5 clk_i = ~clk_i;

  // Beats are counted in the cycle where req and ack are both high
  always @(negedge clk_i) begin
    if (rst_ni && entropy_req) begin
      req_seen = 1'b1;
      if (entropy_ack) beat_cnt++;
    end
  end

  // Entropy source, acks each request after 0 to 3 idle cycles
  initial begin
    int delay;
    delay = 0;
    forever begin
      @(posedge clk_i);
      #1;
      if (entropy_ack) begin
        entropy_ack = 1'b0;
        delay = $unsigned($random(seed)) % 4;
      end else if (entropy_req) begin
        if (delay == 0) begin
          entropy_ack = 1'b1;
          entropy     = $random(seed);
        end else begin
          delay--;
        end
      end
    end
  end

  function automatic logic [63:0] host_pattern(int b, int w);
    return {16'hC0DE, 4'(b), 4'(w), 8'h5A, 32'h1357_9BDF ^ (32'(b * NUM_WORDS + w) << 3)};
  endfunction

  task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("Fail %s got 0x%0h exp 0x%0h", name, got, exp);
    end
  endtask

  task automatic check_true(input string what, input bit cond);
    chk_cnt++;
    if (!cond) begin
      err_cnt++;
      $display("Error: %s", what);
    end
  endtask

  // Setup phase, then access phase, PSLVERR taken mid access
  task automatic apb_write(input logic [APB_AW-1:0] addr, input logic [APB_DW-1:0] data);
    paddr   = addr;
    pwdata  = data;
    pwrite  = 1'b1;
    psel    = 1'b1;
    penable = 1'b0;
    @(posedge clk_i);
    #1 penable = 1'b1;
    @(negedge clk_i);
    last_slverr = pslverr;
    check_eq("pready_o", pready, 1);
    @(posedge clk_i);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_read(input logic [APB_AW-1:0] addr, output logic [APB_DW-1:0] data);
    paddr   = addr;
    pwrite  = 1'b0;
    psel    = 1'b1;
    penable = 1'b0;
    @(posedge clk_i);
    #1 penable = 1'b1;
    @(negedge clk_i);
    data = prdata;
    check_eq("pready_o", pready, 1);
    @(posedge clk_i);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic write_word(input int b, input int w, input logic [63:0] val);
    apb_write(REG_ADDR, 32'({2'(b), 2'(w)}));
    apb_write(REG_DATA_LO, val[31:0]);
    apb_write(REG_DATA_HI, val[63:32]);
  endtask

  task automatic read_word(input int b, input int w, output logic [63:0] val);
    apb_write(REG_ADDR, 32'({2'(b), 2'(w)}));
    apb_read(REG_DATA_LO, val[31:0]);
    apb_read(REG_DATA_HI, val[63:32]);
  endtask

  task automatic send_cmd(input wipe_cmd_e op, input int bank);
    apb_write(REG_CMD, {26'd0, 2'(bank), 2'd0, op});
  endtask

  // Poll STATUS until busy clears, last read stays in status_word
  task automatic wait_idle();
    bit idle;
    idle = 1'b0;
    for (int n = 0; n < 200 && !idle; n++) begin
      apb_read(REG_STATUS, status_word);
      idle = !status_word[0];
    end
    if (!idle) begin
      err_cnt++;
      $display("Timeout: busy did not clear within 200 status polls");
    end
  endtask

  initial begin
    logic [63:0] val;
    paddr       = '0;
    psel        = 1'b0;
    penable     = 1'b0;
    pwrite      = 1'b0;
    pwdata      = '0;
    entropy_ack = 1'b0;
    entropy     = '0;
    rst_ni      = 1'b0;
    repeat (5) @(posedge clk_i);
    #1 rst_ni = 1'b1;

    // Idle state after reset
    check_eq("entropy_req_o", entropy_req, 0);
    check_eq("pslverr_o", pslverr, 0);
    apb_read(REG_STATUS, status_word);
    check_eq("status", status_word, 0);

    // Host writes land in share0 only, so readback is the plain value
    for (int b = 0; b < NUM_BANKS; b++)
      for (int w = 0; w < NUM_WORDS; w++) write_word(b, w, host_pattern(b, w));
    for (int b = 0; b < NUM_BANKS; b++) begin
      for (int w = 0; w < NUM_WORDS; w++) begin
        read_word(b, w, val);
        check_eq("prdata word", val, host_pattern(b, w));
      end
    end

    // Reseed takes exactly two beats
    beat_cnt = 0;
    req_seen = 1'b0;
    send_cmd(CMD_RESEED, 0);
    wait_idle();
    check_true("entropy_req_o never rose during reseed", req_seen);
    check_eq("entropy beats", beat_cnt, 2);
    check_eq("entropy_req_o", entropy_req, 0);
    check_eq("status seeded", status_word[1], 1);

    // Single-bank wipe touches bank 2 only
    send_cmd(CMD_WIPE_BANK, 2);
    wait_idle();
    check_eq("wiped mask", status_word[11:8], 4'b0100);
    for (int b = 0; b < NUM_BANKS; b++) begin
      for (int w = 0; w < NUM_WORDS; w++) begin
        read_word(b, w, val);
        if (b == 2) begin
          check_true("wiped word kept old or zero value",
                     val !== host_pattern(b, w) && val !== '0);
        end else begin
          check_eq("prdata word", val, host_pattern(b, w));
        end
      end
    end

    // Two wipe-all passes must give fresh data everywhere
    send_cmd(CMD_WIPE_ALL, 0);
    wait_idle();
    check_eq("wiped mask", status_word[11:8], 4'b1111);
    for (int b = 0; b < NUM_BANKS; b++)
      for (int w = 0; w < NUM_WORDS; w++) read_word(b, w, first_wipe[b][w]);
    send_cmd(CMD_WIPE_ALL, 0);
    wait_idle();
    check_eq("wiped mask", status_word[11:8], 4'b1111);
    for (int b = 0; b < NUM_BANKS; b++) begin
      for (int w = 0; w < NUM_WORDS; w++) begin
        read_word(b, w, val);
        check_true("word unchanged between two wipes", val !== first_wipe[b][w]);
      end
    end
    write_word(1, 0, host_pattern(1, 0));
    apb_read(REG_STATUS, status_word);
    check_eq("wiped mask", status_word[11:8], 4'b1101);

    // Second command during a wipe is refused
    send_cmd(CMD_WIPE_ALL, 0);
    check_eq("pslverr_o", last_slverr, 0);
    send_cmd(CMD_WIPE_BANK, 0);
    check_eq("pslverr_o", last_slverr, 1);
    wait_idle();
    check_eq("wiped mask", status_word[11:8], 4'b1111);

    $display("checks %0d errors %0d", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// File: list.f
logic/wipe_pkg.sv
logic/wipe_prng.sv
logic/wipe_ctrl.sv
logic/wipe_bank.sv
logic/wipe_apb_regs.sv
logic/wipe_top.sv
bench/wipe_sva.sv
bench/wipe_tb.sv

// File: Makefile
# Verilator flow for the secure-wipe register file
TOP = wipe_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f list.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -Mdir obj_dir -f list.f
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "sim passed" sim.log

clean:
	rm -rf obj_dir sim.log
